// File: vlog.f
rtl/cache_pkg.sv
rtl/cache_direct.sv
rtl/line_memory.sv
rtl/mem_subsystem.sv
dv/tb_clock.sv
dv/tb_top.sv

// File: Makefile
BIN = obj_dir/Vtb_top
SOURCES = $(wildcard rtl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f vlog.f

run: $(BIN)
	./$(BIN) 2>&1 | tee sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Directed testbench for the cache subsystem
////////////////////////////////////////////////////////////////////////////

module tb_top;

	import cache_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int ACCESS_LIMIT = 4 * MEM_LATENCY + 8;
	localparam int WATCHDOG_CYCLES = 200 * ACCESS_LIMIT;
	// Reference covers the first 4 KiB below the memory alias point
	localparam int REF_WORDS = 1024;
	localparam addr_t WINDOW_BASE = 32'h0000_0400;

	logic clk;
	logic reset;
	addr_t addr;
	logic read_write;
	logic master_enable;
	logic byte_enable;
	word_t data_in;
	word_t data_out;
	logic hit;

	word_t ref_mem [REF_WORDS];
	logic written [REF_WORDS];
	logic [31:0] lfsr_state;
	int error_count;
	int check_count;

	tb_clock u_clock (
		.clk (clk)
	);

	mem_subsystem u_mem_subsystem (
		.clk           (clk),
		.reset         (reset),
		.addr          (addr),
		.read_write    (read_write),
		.master_enable (master_enable),
		.byte_enable   (byte_enable),
		.data_in       (data_in),
		.data_out      (data_out),
		.hit           (hit)
	);

	////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////

	// Taps x^32 + x^22 + x^2 + x + 1 with one step per bit
	function automatic logic [31:0] lfsr_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	// Byte reads come back zero-extended
	function automatic word_t expected_read(input addr_t a, input logic be);
		word_t w;
		w = ref_mem[int'(a[11:2])];
		if (be) begin
			return {24'd0, w[int'(a[1:0]) * 8 +: 8]};
		end
		return w;
	endfunction

	task automatic check_equal(input word_t actual, input word_t expected, input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Runs from edge plus 1 ns to edge plus 1 ns and ends on an idle cycle
	task automatic run_access(input logic rd, input logic be, input addr_t a, input word_t d,
			output word_t result, output int cycles);
		cycles = 0;
		result = '0;
		addr = a;
		read_write = rd;
		byte_enable = be;
		data_in = d;
		master_enable = 1'b1;
		while (!hit && cycles < ACCESS_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (hit) begin
			result = data_out;
		end else begin
			error_count++;
			$display("Access to address %h never completed within %0d cycles", a, ACCESS_LIMIT);
		end
		// Request stays up through the hit cycle
		@(posedge clk);
		#1;
		check_equal(word_t'(hit), 32'd0, "single hit per request");
		master_enable = 1'b0;
		@(posedge clk);
		#1;
		check_equal(word_t'(hit), 32'd0, "hit low while master_enable is low");
	endtask

	task automatic store(input addr_t a, input logic be, input word_t d, input string what,
			output int cycles);
		word_t result;
		word_t echo;
		int widx;
		widx = int'(a[11:2]);
		echo = be ? {24'd0, d[7:0]} : d;
		run_access(1'b0, be, a, d, result, cycles);
		check_equal(result, echo, what);
		if (be) begin
			ref_mem[widx][int'(a[1:0]) * 8 +: 8] = d[7:0];
		end else begin
			ref_mem[widx] = d;
			written[widx] = 1'b1;
		end
	endtask

	task automatic load(input addr_t a, input logic be, input string what, output int cycles);
		word_t result;
		word_t expected;
		expected = expected_read(a, be);
		run_access(1'b1, be, a, 32'd0, result, cycles);
		check_equal(result, expected, what);
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s finished with %0d errors", name, error_count - errors_before);
	endtask

	////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////

	task automatic word_line_test();
		int errors_before;
		int cycles;
		addr_t base;
		errors_before = error_count;
		base = 32'h0000_0100;
		// First store misses and fills and the rest hit
		for (int i = 0; i < 4; i++) begin
			store(base + addr_t'(i * 4), 1'b0, 32'hC0DE_0000 | word_t'(i), "word write echo", cycles);
		end
		for (int i = 0; i < 4; i++) begin
			load(base + addr_t'(i * 4), 1'b0, "word read", cycles);
			check_equal(word_t'(cycles), 32'd1, "resident read latency");
		end
		report_test("word_line", errors_before);
	endtask

	task automatic byte_merge_test();
		int errors_before;
		int cycles;
		addr_t base;
		errors_before = error_count;
		base = 32'h0000_0184;
		store(base, 1'b0, 32'h1122_3344, "word write echo", cycles);
		store(base, 1'b1, 32'h0000_00AA, "byte write echo", cycles);
		store(base + 32'd2, 1'b1, 32'h0000_005C, "byte write echo", cycles);
		// Upper bits of data_in are ignored on a byte write
		store(base + 32'd3, 1'b1, 32'hFFFF_FF07, "byte write echo", cycles);
		load(base, 1'b0, "merged word read", cycles);
		for (int i = 0; i < 4; i++) begin
			load(base + addr_t'(i), 1'b1, "byte read", cycles);
		end
		report_test("byte_merge", errors_before);
	endtask

	task automatic dirty_evict_test();
		int errors_before;
		int cycles;
		addr_t a;
		errors_before = error_count;
		a = 32'h0000_0320;
		store(a, 1'b0, 32'hDEAD_0320, "word write echo", cycles);
		// Same index with the next tag
		store(a + 32'd64, 1'b0, 32'hBEEF_0360, "word write echo", cycles);
		load(a, 1'b0, "read after write-back and refill", cycles);
		check_equal(word_t'(cycles > MEM_LATENCY), 32'd1, "refill takes the memory latency");
		load(a + 32'd64, 1'b0, "read of evicted conflicting line", cycles);
		report_test("dirty_evict", errors_before);
	endtask

	task automatic timing_test();
		int errors_before;
		int hit_cycles;
		int miss_cycles;
		int cycles;
		addr_t a;
		addr_t b;
		errors_before = error_count;
		a = 32'h0000_0200;
		b = 32'h0000_0280;
		store(a, 1'b0, 32'h0F0F_0200, "word write echo", cycles);
		load(a, 1'b0, "read of just accessed word", hit_cycles);
		check_equal(word_t'(hit_cycles), 32'd1, "hit latency");
		store(b, 1'b0, 32'hF0F0_0280, "conflicting write echo", miss_cycles);
		check_equal(word_t'(miss_cycles >= hit_cycles + MEM_LATENCY), 32'd1,
			"miss slower than hit by the memory latency");
		load(b, 1'b0, "read of conflicting word", cycles);
		check_equal(word_t'(cycles), 32'd1, "hit latency after miss");
		repeat (3) begin
			@(posedge clk);
			#1;
			check_equal(word_t'(hit), 32'd0, "hit low with no request");
		end
		report_test("timing", errors_before);
	endtask

	task automatic random_traffic_test();
		int errors_before;
		int cycles;
		int widx;
		logic [31:0] bits;
		logic rd;
		logic be;
		addr_t a;
		errors_before = error_count;
		for (int n = 0; n < 150; n++) begin
			bits = lfsr_bits(1);
			rd = bits[0];
			bits = lfsr_bits(1);
			be = bits[0];
			// 512-byte window spans all indexes and eight tags
			bits = lfsr_bits(9);
			a = WINDOW_BASE + addr_t'(bits[8:0]);
			if (!be) begin
				a[1:0] = 2'b00;
			end
			widx = int'(a[11:2]);
			// Unwritten word becomes a whole-word write
			if (!written[widx]) begin
				rd = 1'b0;
				be = 1'b0;
				a[1:0] = 2'b00;
			end
			if (rd) begin
				load(a, be, "random read", cycles);
			end else begin
				bits = lfsr_bits(32);
				store(a, be, bits, "random write echo", cycles);
			end
		end
		report_test("random_traffic", errors_before);
	endtask

	////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		addr = '0;
		read_write = 1'b1;
		master_enable = 1'b0;
		byte_enable = 1'b0;
		data_in = '0;
		lfsr_state = 32'h539a_5be1;
		error_count = 0;
		check_count = 0;
		for (int i = 0; i < REF_WORDS; i++) begin
			ref_mem[i] = '0;
			written[i] = 1'b0;
		end

		repeat (10) @(posedge clk);
		#1;
		check_equal(word_t'(hit), 32'd0, "hit low in reset");
		reset = 1'b0;

		word_line_test();
		byte_merge_test();
		dirty_evict_test();
		timing_test();
		random_traffic_test();

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Testbench clock source
////////////////////////////////////////////////////////////////////////////

module tb_clock (
	output logic clk
);

	// 4 ns period
	localparam int HALF_PERIOD = 2;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Cache in front of main memory
////////////////////////////////////////////////////////////////////////////

module mem_subsystem (
	input wire logic clk,
	input wire logic reset,
	input wire cache_pkg::addr_t addr,
	input wire logic read_write,
	input wire logic master_enable,
	input wire logic byte_enable,
	input wire cache_pkg::word_t data_in,
	output cache_pkg::word_t data_out,
	output logic hit
);

	import cache_pkg::*;

	// Cache to memory
	logic mem_write_req;
	addr_t mem_write_addr;
	line_t mem_write_data;
	logic mem_write_ack;
	logic mem_read_req;
	addr_t mem_read_addr;
	line_t mem_read_data;
	logic mem_read_ack;

	cache_direct u_cache (
		.clk            (clk),
		.reset          (reset),
		.addr           (addr),
		.read_write     (read_write),
		.master_enable  (master_enable),
		.byte_enable    (byte_enable),
		.data_in        (data_in),
		.data_out       (data_out),
		.hit            (hit),
		.mem_write_req  (mem_write_req),
		.mem_write_addr (mem_write_addr),
		.mem_write_data (mem_write_data),
		.mem_write_ack  (mem_write_ack),
		.mem_read_req   (mem_read_req),
		.mem_read_addr  (mem_read_addr),
		.mem_read_data  (mem_read_data),
		.mem_read_ack   (mem_read_ack)
	);

	line_memory u_memory (
		.clk            (clk),
		.reset          (reset),
		.mem_write_req  (mem_write_req),
		.mem_write_addr (mem_write_addr),
		.mem_write_data (mem_write_data),
		.mem_write_ack  (mem_write_ack),
		.mem_read_req   (mem_read_req),
		.mem_read_addr  (mem_read_addr),
		.mem_read_data  (mem_read_data),
		.mem_read_ack   (mem_read_ack)
	);

endmodule

`default_nettype wire

// File: rtl/line_memory.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Line-wide main memory with fixed latency
////////////////////////////////////////////////////////////////////////////

module line_memory (
	input wire logic clk,
	input wire logic reset,
	// Write channel
	input wire logic mem_write_req,
	input wire cache_pkg::addr_t mem_write_addr,
	input wire cache_pkg::line_t mem_write_data,
	output logic mem_write_ack,
	// Read channel
	input wire logic mem_read_req,
	input wire cache_pkg::addr_t mem_read_addr,
	output cache_pkg::line_t mem_read_data,
	output logic mem_read_ack
);

	import cache_pkg::*;

	line_t mem [MEM_LINES];

	// Line address modulo MEM_LINES
	mem_index_t write_index;
	mem_index_t read_index;

	logic busy;
	logic serve_write;
	lat_count_t count;
	logic start;
	logic done;

	assign write_index = mem_write_addr[OFFSET_BITS +: MEM_INDEX_BITS];
	assign read_index = mem_read_addr[OFFSET_BITS +: MEM_INDEX_BITS];

	// No new request in the ack cycle, the requester is still dropping it
	assign start = !busy && !mem_write_ack && !mem_read_ack
		&& (mem_write_req || mem_read_req);
	assign done = busy && (count == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			serve_write <= 1'b0;
			count <= '0;
			mem_write_ack <= 1'b0;
			mem_read_ack <= 1'b0;
		end else begin
			mem_write_ack <= 1'b0;
			mem_read_ack <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				// Write wins when both show up together
				serve_write <= mem_write_req;
				count <= lat_count_t'(MEM_LATENCY - 1);
			end else if (done) begin
				busy <= 1'b0;
				if (serve_write) begin
					mem_write_ack <= 1'b1;
				end else begin
					mem_read_ack <= 1'b1;
				end
			end else if (busy) begin
				count <= count - 1'b1;
			end
		end
	end

	// Commit or fetch in the cycle the ack is raised
	always_ff @(posedge clk) begin
		if (done && serve_write) begin
			mem[write_index] <= mem_write_data;
		end
		if (done && !serve_write) begin
			mem_read_data <= mem[read_index];
		end
	end

	// Acks only answer a pending request
	assert property (@(posedge clk) disable iff (reset)
		mem_write_ack |-> mem_write_req);

	assert property (@(posedge clk) disable iff (reset)
		mem_read_ack |-> mem_read_req);

endmodule

`default_nettype wire

// File: rtl/cache_direct.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Direct-mapped write-back data cache
////////////////////////////////////////////////////////////////////////////

module cache_direct (
	input wire logic clk,
	input wire logic reset,
	// Requester side
	input wire cache_pkg::addr_t addr,
	input wire logic read_write,
	input wire logic master_enable,
	input wire logic byte_enable,
	input wire cache_pkg::word_t data_in,
	output cache_pkg::word_t data_out,
	output logic hit,
	// Memory write channel
	output logic mem_write_req,
	output cache_pkg::addr_t mem_write_addr,
	output cache_pkg::line_t mem_write_data,
	input wire logic mem_write_ack,
	// Memory read channel
	output logic mem_read_req,
	output cache_pkg::addr_t mem_read_addr,
	input wire cache_pkg::line_t mem_read_data,
	input wire logic mem_read_ack
);

	import cache_pkg::*;

	// Address fields, tag | index | offset
	tag_t addr_tag;
	index_t addr_index;
	logic [OFFSET_BITS-1:0] addr_offset;
	logic [OFFSET_BITS-3:0] word_sel;

	// Fill target taken from the outstanding read
	tag_t fill_tag;
	index_t fill_index;

	// Storage
	tag_t tags [CACHE_LINES];
	line_t lines [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_bits;
	logic [CACHE_LINES-1:0] dirty_bits;

	cache_state_t state;

	logic hit_int;
	logic request_open;
	logic lookup_hit;
	logic lookup_miss;
	logic victim_dirty;
	word_t line_word;
	byte_t line_byte;

	assign addr_tag = addr[31 -: TAG_BITS];
	assign addr_index = addr[OFFSET_BITS +: INDEX_BITS];
	assign addr_offset = addr[OFFSET_BITS-1:0];
	assign word_sel = addr_offset[OFFSET_BITS-1:2];

	assign fill_tag = mem_read_addr[31 -: TAG_BITS];
	assign fill_index = mem_read_addr[OFFSET_BITS +: INDEX_BITS];

	// Tag compare against the indexed line
	assign hit_int = valid_bits[addr_index] && (tags[addr_index] == addr_tag);

	// The cycle holding hit still sees the old request, so skip it
	assign request_open = master_enable && !hit && (state == CACHE_IDLE);
	assign lookup_hit = request_open && hit_int;
	assign lookup_miss = request_open && !hit_int;

	assign victim_dirty = valid_bits[addr_index] && dirty_bits[addr_index];

	// Little-endian lane select
	assign line_word = lines[addr_index][word_sel*32 +: 32];
	assign line_byte = lines[addr_index][addr_offset*8 +: 8];

	////////////////////////////////////////////////////////////////////////
	// Control: FSM, request strobes, valid and dirty bits
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CACHE_IDLE;
			hit <= 1'b0;
			mem_write_req <= 1'b0;
			mem_read_req <= 1'b0;
			valid_bits <= '0;
			dirty_bits <= '0;
		end else begin
			hit <= 1'b0;
			case (state)
				CACHE_IDLE: begin
					if (lookup_hit) begin
						hit <= 1'b1;
						if (!read_write) begin
							dirty_bits[addr_index] <= 1'b1;
						end
					end else if (lookup_miss) begin
						// Write back a dirty victim before the fill
						if (victim_dirty) begin
							mem_write_req <= 1'b1;
							state <= CACHE_EVICT;
						end else begin
							mem_read_req <= 1'b1;
							state <= CACHE_FILL;
						end
					end
				end
				CACHE_EVICT: begin
					if (mem_write_ack) begin
						mem_write_req <= 1'b0;
						mem_read_req <= 1'b1;
						state <= CACHE_FILL;
					end
				end
				CACHE_FILL: begin
					if (mem_read_ack) begin
						mem_read_req <= 1'b0;
						valid_bits[fill_index] <= 1'b1;
						dirty_bits[fill_index] <= 1'b0;
						state <= CACHE_RETRY;
					end
				end
				// Next cycle the lookup is a hit
				CACHE_RETRY: state <= CACHE_IDLE;
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Data path: line storage, lane merge, memory addresses
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (lookup_hit) begin
			if (read_write) begin
				data_out <= byte_enable ? word_t'(line_byte) : line_word;
			end else if (byte_enable) begin
				lines[addr_index][addr_offset*8 +: 8] <= data_in[7:0];
				data_out <= word_t'(data_in[7:0]);
			end else begin
				lines[addr_index][word_sel*32 +: 32] <= data_in;
				data_out <= data_in;
			end
		end

		// Victim goes back to its own line address
		if (lookup_miss) begin
			mem_write_addr <= {tags[addr_index], addr_index, {OFFSET_BITS{1'b0}}};
			mem_write_data <= lines[addr_index];
			mem_read_addr <= {addr_tag, addr_index, {OFFSET_BITS{1'b0}}};
		end

		if (state == CACHE_FILL && mem_read_ack) begin
			lines[fill_index] <= mem_read_data;
			tags[fill_index] <= fill_tag;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	// Only one memory channel busy at a time
	assert property (@(posedge clk) disable iff (reset)
		!(mem_write_req && mem_read_req));

	// A completion always answers an enabled request
	assert property (@(posedge clk) disable iff (reset)
		hit |-> $past(master_enable));

endmodule

`default_nettype wire

// File: rtl/cache_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Cache and main memory geometry
////////////////////////////////////////////////////////////////////////////

package cache_pkg;

	// One line holds four 32-bit words
	localparam int LINE_BITS = 128;

	// Direct-mapped, four lines
	localparam int CACHE_LINES = 4;

	// Byte offset within a line
	localparam int OFFSET_BITS = 4;

	// Line index into the cache
	localparam int INDEX_BITS = 2;

	// Whatever is left of the byte address
	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

	// Main memory size in lines, aliases above 4 KiB
	localparam int MEM_LINES = 256;
	localparam int MEM_INDEX_BITS = $clog2(MEM_LINES);

	// Cycles from a request being seen to its ack
	localparam int MEM_LATENCY = 3;
	localparam int LAT_BITS = $clog2(MEM_LATENCY + 1);

	////////////////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	// Line slot inside the main memory
	typedef logic [MEM_INDEX_BITS-1:0] mem_index_t;

	// Memory latency down-counter
	typedef logic [LAT_BITS-1:0] lat_count_t;

	////////////////////////////////////////////////////////////////////////
	// Miss handling FSM
	////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_EVICT,
		CACHE_FILL,
		CACHE_RETRY
	} cache_state_t;

endpackage

`default_nettype wire
